//--- source/isa_pkg.sv
package isa_pkg;

  localparam int data_width    = 32;
  localparam int reg_addr_bits = 5;
  localparam int num_regs      = 32;

  // instruction field positions
  localparam int opcode_msb = 31;
  localparam int opcode_lsb = 26;
  localparam int rs_msb     = 25;
  localparam int rs_lsb     = 21;
  localparam int rt_msb     = 20;
  localparam int rt_lsb     = 16;
  localparam int rd_msb     = 15;
  localparam int rd_lsb     = 11;
  localparam int imm_msb    = 15;
  localparam int imm_lsb    = 0;
  localparam int imm_width  = 16;

  typedef enum logic [5:0] {
    op_nop  = 6'h00,
    op_add  = 6'h01,
    op_sub  = 6'h02,
    op_and  = 6'h03,
    op_or   = 6'h04,
    op_slt  = 6'h05,
    op_addi = 6'h08,
    op_andi = 6'h0c,
    op_ori  = 6'h0d,
    op_lw   = 6'h23,
    op_sw   = 6'h2b
  } opcode_t;

  // alu_slt compares signed
  typedef enum logic [2:0] {
    alu_add = 3'd0,
    alu_sub = 3'd1,
    alu_and = 3'd2,
    alu_or  = 3'd3,
    alu_slt = 3'd4
  } alu_op_t;

  typedef struct packed {
    alu_op_t alu_op;
    logic    alu_src;
    logic    reg_dst;
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
  } ctrl_t;

endpackage

//--- source/mem_pkg.sv
package mem_pkg;

  // word addressed data memory
  localparam int mem_addr_bits = 8;
  localparam int mem_depth     = 256;

  localparam int num_lanes = 2;

  typedef logic lane_t;

endpackage

//--- source/mem_if.sv
`timescale 1ns/1ps

interface mem_if;

  logic                              req_valid;
  logic                              req_write;
  logic [mem_pkg::mem_addr_bits-1:0] req_addr;
  logic [isa_pkg::data_width-1:0]    req_wdata;
  logic                              req_ready;

  // one cycle after the accepting edge, reads only
  logic                              resp_valid;
  logic [isa_pkg::data_width-1:0]    resp_rdata;

  modport lane (
    output req_valid, req_write, req_addr, req_wdata,
    input  req_ready, resp_valid, resp_rdata
  );

  modport mem (
    input  req_valid, req_write, req_addr, req_wdata,
    output req_ready, resp_valid, resp_rdata
  );

endinterface

//--- source/control_unit.sv
`timescale 1ns/1ps

module control_unit (
  input  isa_pkg::opcode_t opcode,
  output isa_pkg::ctrl_t   ctrl
);

  always_comb begin
    ctrl = '0;
    case (opcode)
      isa_pkg::op_add,
      isa_pkg::op_sub,
      isa_pkg::op_and,
      isa_pkg::op_or,
      isa_pkg::op_slt: begin
        ctrl.reg_dst   = 1'b1;
        ctrl.reg_write = 1'b1;
        case (opcode)
          isa_pkg::op_sub: ctrl.alu_op = isa_pkg::alu_sub;
          isa_pkg::op_and: ctrl.alu_op = isa_pkg::alu_and;
          isa_pkg::op_or:  ctrl.alu_op = isa_pkg::alu_or;
          isa_pkg::op_slt: ctrl.alu_op = isa_pkg::alu_slt;
          default:         ctrl.alu_op = isa_pkg::alu_add;
        endcase
      end
      // immediates are zero extended in the lane
      isa_pkg::op_addi: begin
        ctrl.alu_src   = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      isa_pkg::op_andi: begin
        ctrl.alu_op    = isa_pkg::alu_and;
        ctrl.alu_src   = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      isa_pkg::op_ori: begin
        ctrl.alu_op    = isa_pkg::alu_or;
        ctrl.alu_src   = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      isa_pkg::op_lw: begin
        ctrl.alu_src   = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.mem_read  = 1'b1;
      end
      isa_pkg::op_sw: begin
        ctrl.alu_src   = 1'b1;
        ctrl.mem_write = 1'b1;
      end
      // nop and unknown opcodes keep everything inactive
      default: ctrl = '0;
    endcase
  end

endmodule

//--- source/alu.sv
`timescale 1ns/1ps

module alu (
  input  isa_pkg::alu_op_t               alu_op,
  input  logic [isa_pkg::data_width-1:0] a,
  input  logic [isa_pkg::data_width-1:0] b,
  output logic [isa_pkg::data_width-1:0] result
);

  always_comb begin
    case (alu_op)
      isa_pkg::alu_add: result = a + b;
      isa_pkg::alu_sub: result = a - b;
      isa_pkg::alu_and: result = a & b;
      isa_pkg::alu_or:  result = a | b;
      isa_pkg::alu_slt: begin
        result = {{(isa_pkg::data_width-1){1'b0}}, $signed(a) < $signed(b)};
      end
      default: result = '0;
    endcase
  end

  // decoder must never hand over one of the spare encodings
  always_comb begin
    assert (alu_op inside {isa_pkg::alu_add, isa_pkg::alu_sub, isa_pkg::alu_and,
                           isa_pkg::alu_or, isa_pkg::alu_slt})
      else $error("alu: undefined operation %0d", alu_op);
  end

endmodule

//--- source/exec_lane.sv
`timescale 1ns/1ps

module exec_lane (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                instruction_valid,
  output logic                                instruction_ready,
  input  logic [isa_pkg::data_width-1:0]      instruction,
  output logic                                retire_valid,
  output logic                                retire_write,
  output logic [isa_pkg::reg_addr_bits-1:0]   retire_reg,
  output logic [isa_pkg::data_width-1:0]      retire_data,
  mem_if.lane                                 mem
);

  typedef enum logic [1:0] {st_idle, st_request, st_wait, st_retire} state_t;

  state_t                              state;
  isa_pkg::ctrl_t                      ctrl;
  logic [isa_pkg::reg_addr_bits-1:0]   rs;
  logic [isa_pkg::reg_addr_bits-1:0]   rt;
  logic [isa_pkg::reg_addr_bits-1:0]   rd;
  logic [isa_pkg::imm_width-1:0]       imm;
  logic [isa_pkg::data_width-1:0]      regs [isa_pkg::num_regs];
  logic [isa_pkg::data_width-1:0]      rs_value;
  logic [isa_pkg::data_width-1:0]      rt_value;
  logic [isa_pkg::data_width-1:0]      operand_b;
  logic [isa_pkg::data_width-1:0]      alu_result;
  logic [isa_pkg::reg_addr_bits-1:0]   dest;
  logic                                accept;

  // held for the life of one instruction
  logic [isa_pkg::reg_addr_bits-1:0]   dest_q;
  logic [isa_pkg::data_width-1:0]      data_q;
  logic [mem_pkg::mem_addr_bits-1:0]   addr_q;
  logic                                write_q;
  logic                                store_q;

  //////////////////////////////////////////////////////////////////////
  // decode and execute, all in the accept cycle
  //////////////////////////////////////////////////////////////////////

  assign rs  = instruction[isa_pkg::rs_msb:isa_pkg::rs_lsb];
  assign rt  = instruction[isa_pkg::rt_msb:isa_pkg::rt_lsb];
  assign rd  = instruction[isa_pkg::rd_msb:isa_pkg::rd_lsb];
  assign imm = instruction[isa_pkg::imm_msb:isa_pkg::imm_lsb];

  control_unit u_control_unit (
    .opcode (isa_pkg::opcode_t'(instruction[isa_pkg::opcode_msb:isa_pkg::opcode_lsb])),
    .ctrl   (ctrl)
  );

  // r0 is hardwired
  assign rs_value  = (rs == '0) ? '0 : regs[rs];
  assign rt_value  = (rt == '0) ? '0 : regs[rt];
  assign operand_b = ctrl.alu_src ?
                     {{(isa_pkg::data_width-isa_pkg::imm_width){1'b0}}, imm} : rt_value;
  assign dest      = ctrl.reg_dst ? rd : rt;

  alu u_alu (
    .alu_op (ctrl.alu_op),
    .a      (rs_value),
    .b      (operand_b),
    .result (alu_result)
  );

  assign accept = (state == st_idle) && instruction_valid;

  //////////////////////////////////////////////////////////////////////
  // sequencing
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (instruction_valid) begin
            state <= (ctrl.mem_read || ctrl.mem_write) ? st_request : st_retire;
          end
        end
        st_request: begin
          if (mem.req_ready) begin
            state <= store_q ? st_retire : st_wait;
          end
        end
        st_wait: begin
          if (mem.resp_valid) begin
            state <= st_retire;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      dest_q  <= dest;
      addr_q  <= alu_result[mem_pkg::mem_addr_bits-1:0];
      write_q <= ctrl.reg_write && (dest != '0);
      store_q <= ctrl.mem_write;
      if (ctrl.reg_write) begin
        data_q <= alu_result;
      end else if (ctrl.mem_write) begin
        data_q <= rt_value;
      end else begin
        data_q <= '0;
      end
    end else if (state == st_wait && mem.resp_valid) begin
      data_q <= mem.resp_rdata;
    end
  end

  // written as the retire cycle ends
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < isa_pkg::num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (state == st_retire && write_q) begin
      regs[dest_q] <= data_q;
    end
  end

  assign instruction_ready = (state == st_idle);
  assign mem.req_valid     = (state == st_request);
  assign mem.req_write     = store_q;
  assign mem.req_addr      = addr_q;
  assign mem.req_wdata     = data_q;

  assign retire_valid = (state == st_retire);
  assign retire_write = write_q;
  assign retire_reg   = dest_q;
  assign retire_data  = data_q;

  // request held until the arbiter takes it
  assert property (@(posedge clk) disable iff (reset)
    mem.req_valid && !mem.req_ready |=> mem.req_valid && $stable(mem.req_write) &&
      $stable(mem.req_addr) && $stable(mem.req_wdata))
    else $error("exec_lane: memory request changed before acceptance");

  assert property (@(posedge clk) disable iff (reset) retire_valid |=> !retire_valid)
    else $error("exec_lane: retire held for two cycles");

endmodule

//--- source/data_memory.sv
`timescale 1ns/1ps

module data_memory (
  input  logic clk,
  input  logic reset,
  mem_if.mem   port0,
  mem_if.mem   port1
);

  logic [isa_pkg::data_width-1:0]    storage [mem_pkg::mem_depth];
  logic [mem_pkg::num_lanes-1:0]     request;
  logic [mem_pkg::num_lanes-1:0]     grant;
  mem_pkg::lane_t                    last_grant;
  mem_pkg::lane_t                    sel;
  mem_pkg::lane_t                    resp_lane;
  logic                              resp_pending;
  logic [isa_pkg::data_width-1:0]    rdata;
  logic                              sel_write;
  logic [mem_pkg::mem_addr_bits-1:0] sel_addr;
  logic [isa_pkg::data_width-1:0]    sel_wdata;

  //////////////////////////////////////////////////////////////////////
  // round robin arbiter
  //////////////////////////////////////////////////////////////////////

  assign request = {port1.req_valid, port0.req_valid};

  // on a tie the lane not served last wins
  always_comb begin
    if (&request) begin
      grant = (last_grant == 1'b1) ? 2'b01 : 2'b10;
    end else begin
      grant = request;
    end
  end

  assign sel       = grant[1];
  assign sel_write = sel ? port1.req_write : port0.req_write;
  assign sel_addr  = sel ? port1.req_addr  : port0.req_addr;
  assign sel_wdata = sel ? port1.req_wdata : port0.req_wdata;

  always_ff @(posedge clk) begin
    if (reset) begin
      last_grant   <= 1'b1;
      resp_pending <= 1'b0;
    end else begin
      if (|grant) begin
        last_grant <= sel;
      end
      resp_pending <= (|grant) && !sel_write;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (|grant) begin
      resp_lane <= sel;
      if (sel_write) begin
        storage[sel_addr] <= sel_wdata;
      end else begin
        rdata <= storage[sel_addr];
      end
    end
  end

  assign port0.req_ready  = grant[0];
  assign port1.req_ready  = grant[1];
  assign port0.resp_valid = resp_pending && (resp_lane == 1'b0);
  assign port1.resp_valid = resp_pending && (resp_lane == 1'b1);
  assign port0.resp_rdata = rdata;
  assign port1.resp_rdata = rdata;

  assert property (@(posedge clk) disable iff (reset) !(port0.req_ready && port1.req_ready))
    else $error("data_memory: both lanes granted");

endmodule

//--- source/processor.sv
`timescale 1ns/1ps

module processor (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              instruction0_valid,
  output logic                              instruction0_ready,
  input  logic [isa_pkg::data_width-1:0]    instruction0,
  output logic                              retire0_valid,
  output logic                              retire0_write,
  output logic [isa_pkg::reg_addr_bits-1:0] retire0_reg,
  output logic [isa_pkg::data_width-1:0]    retire0_data,
  input  logic                              instruction1_valid,
  output logic                              instruction1_ready,
  input  logic [isa_pkg::data_width-1:0]    instruction1,
  output logic                              retire1_valid,
  output logic                              retire1_write,
  output logic [isa_pkg::reg_addr_bits-1:0] retire1_reg,
  output logic [isa_pkg::data_width-1:0]    retire1_data
);

  mem_if lane0_bus ();
  mem_if lane1_bus ();

  exec_lane u_lane0 (
    .clk               (clk),
    .reset             (reset),
    .instruction_valid (instruction0_valid),
    .instruction_ready (instruction0_ready),
    .instruction       (instruction0),
    .retire_valid      (retire0_valid),
    .retire_write      (retire0_write),
    .retire_reg        (retire0_reg),
    .retire_data       (retire0_data),
    .mem               (lane0_bus.lane)
  );

  exec_lane u_lane1 (
    .clk               (clk),
    .reset             (reset),
    .instruction_valid (instruction1_valid),
    .instruction_ready (instruction1_ready),
    .instruction       (instruction1),
    .retire_valid      (retire1_valid),
    .retire_write      (retire1_write),
    .retire_reg        (retire1_reg),
    .retire_data       (retire1_data),
    .mem               (lane1_bus.lane)
  );

  // shared by both lanes
  data_memory u_data_memory (
    .clk   (clk),
    .reset (reset),
    .port0 (lane0_bus.mem),
    .port1 (lane1_bus.mem)
  );

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic clk
);

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

endmodule

//--- tests/tb_processor.sv
`timescale 1ns/1ps

module tb_processor;

  localparam int accept_limit = 50;
  localparam int drain_limit  = 100;

  typedef struct packed {
    logic                           valid0;
    logic [isa_pkg::data_width-1:0] instr0;
    logic                           valid1;
    logic [isa_pkg::data_width-1:0] instr1;
    logic                           drain;
  } row_t;

  typedef struct packed {
    logic                              write;
    logic [isa_pkg::reg_addr_bits-1:0] dest;
    logic [isa_pkg::data_width-1:0]    data;
  } exp_t;

  logic                              clk;
  logic                              reset;
  logic                              instruction0_valid;
  logic                              instruction0_ready;
  logic [isa_pkg::data_width-1:0]    instruction0;
  logic                              retire0_valid;
  logic                              retire0_write;
  logic [isa_pkg::reg_addr_bits-1:0] retire0_reg;
  logic [isa_pkg::data_width-1:0]    retire0_data;
  logic                              instruction1_valid;
  logic                              instruction1_ready;
  logic [isa_pkg::data_width-1:0]    instruction1;
  logic                              retire1_valid;
  logic                              retire1_write;
  logic [isa_pkg::reg_addr_bits-1:0] retire1_reg;
  logic [isa_pkg::data_width-1:0]    retire1_data;

  row_t rows [$];
  exp_t exp_q0 [$];
  exp_t exp_q1 [$];
  logic [isa_pkg::data_width-1:0] model_regs [mem_pkg::num_lanes][isa_pkg::num_regs];
  logic [isa_pkg::data_width-1:0] model_mem [mem_pkg::mem_depth];
  int checks;
  int mismatches;
  int other_errors;
  int busy_seen;

  tb_clock u_tb_clock (.clk(clk));

  processor u_processor (.*);

  function automatic logic [31:0] encode_r(input isa_pkg::opcode_t op,
                                           input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] rd);
    return {op, rs, rt, rd, 11'h000};
  endfunction

  function automatic logic [31:0] encode_i(input isa_pkg::opcode_t op,
                                           input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  task automatic add_row(input logic v0, input logic [31:0] i0, input logic v1,
                         input logic [31:0] i1, input logic drain);
    row_t row;
    row.valid0 = v0;
    row.instr0 = i0;
    row.valid1 = v1;
    row.instr1 = i1;
    row.drain  = drain;
    rows.push_back(row);
  endtask

  //////////////////////////////////////////////////////////////////////
  // reference model, one lane at a time in issue order
  //////////////////////////////////////////////////////////////////////

  function automatic exp_t model_step(input mem_pkg::lane_t lane, input logic [31:0] instr);
    logic [5:0]  op;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] zimm;
    logic [31:0] sum;
    logic [31:0] result;
    logic [7:0]  addr;
    logic        writes;
    logic        r_form;
    exp_t        e;
    op     = instr[31:26];
    rs     = instr[25:21];
    rt     = instr[20:16];
    rd     = instr[15:11];
    a      = model_regs[lane][rs];
    b      = model_regs[lane][rt];
    zimm   = {16'h0000, instr[15:0]};
    sum    = a + zimm;
    addr   = sum[7:0];
    r_form = op inside {isa_pkg::op_add, isa_pkg::op_sub, isa_pkg::op_and,
                        isa_pkg::op_or, isa_pkg::op_slt};
    writes = r_form || (op inside {isa_pkg::op_addi, isa_pkg::op_andi, isa_pkg::op_ori,
                                   isa_pkg::op_lw});
    case (op)
      isa_pkg::op_add:  result = a + b;
      isa_pkg::op_sub:  result = a - b;
      isa_pkg::op_and:  result = a & b;
      isa_pkg::op_or:   result = a | b;
      isa_pkg::op_slt:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      isa_pkg::op_addi: result = sum;
      isa_pkg::op_andi: result = a & zimm;
      isa_pkg::op_ori:  result = a | zimm;
      isa_pkg::op_lw:   result = model_mem[addr];
      isa_pkg::op_sw:   result = b;
      default:          result = 32'd0;
    endcase
    if (op == isa_pkg::op_sw) begin
      model_mem[addr] = b;
    end
    e.dest  = r_form ? rd : rt;
    e.write = writes && (e.dest != 5'd0);
    e.data  = result;
    if (e.write) begin
      model_regs[lane][e.dest] = result;
    end
    return e;
  endfunction

  function automatic logic lane_ready(input mem_pkg::lane_t lane);
    return lane ? instruction1_ready : instruction0_ready;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // retire checking, sampled mid cycle
  //////////////////////////////////////////////////////////////////////

  task automatic check_retire(input mem_pkg::lane_t lane, input logic w,
                              input logic [4:0] r, input logic [31:0] d);
    exp_t e;
    if ((lane == 1'b0 && exp_q0.size() == 0) || (lane == 1'b1 && exp_q1.size() == 0)) begin
      $display("ERROR: lane %0d retired with no instruction outstanding", lane);
      other_errors++;
    end else begin
      e = lane ? exp_q1.pop_front() : exp_q0.pop_front();
      checks++;
      if (w !== e.write) begin
        $display("MISMATCH: retire%0d_write got %h expected %h", lane, w, e.write);
        mismatches++;
      end
      if (e.write && (r !== e.dest)) begin
        $display("MISMATCH: retire%0d_reg got %h expected %h", lane, r, e.dest);
        mismatches++;
      end
      if (d !== e.data) begin
        $display("MISMATCH: retire%0d_data got %h expected %h", lane, d, e.data);
        mismatches++;
      end
    end
  endtask

  always @(negedge clk) begin
    if (!reset && retire0_valid) begin
      check_retire(1'b0, retire0_write, retire0_reg, retire0_data);
    end
    if (!reset && retire1_valid) begin
      check_retire(1'b1, retire1_write, retire1_reg, retire1_data);
    end
  end

  // called on a falling edge with valid already driven
  task automatic wait_accept(input mem_pkg::lane_t lane);
    int waited;
    waited = 0;
    if (!lane_ready(lane)) begin
      busy_seen++;
    end
    while (!lane_ready(lane) && waited < accept_limit) begin
      @(negedge clk);
      waited++;
    end
    if (lane_ready(lane)) begin
      @(posedge clk);
      @(negedge clk);
    end else begin
      $display("ERROR: lane %0d did not accept its instruction within %0d cycles",
               lane, waited);
      other_errors++;
      if (lane) begin
        void'(exp_q1.pop_back());
      end else begin
        void'(exp_q0.pop_back());
      end
    end
    if (lane) begin
      instruction1_valid = 1'b0;
    end else begin
      instruction0_valid = 1'b0;
    end
  endtask

  task automatic apply_row(input row_t row);
    instruction0_valid = row.valid0;
    instruction0       = row.instr0;
    instruction1_valid = row.valid1;
    instruction1       = row.instr1;
    if (row.valid0) begin
      exp_q0.push_back(model_step(1'b0, row.instr0));
    end
    if (row.valid1) begin
      exp_q1.push_back(model_step(1'b1, row.instr1));
    end
    fork
      if (row.valid0) wait_accept(1'b0);
      if (row.valid1) wait_accept(1'b1);
    join
  endtask

  task automatic drain_retires();
    int waited;
    waited = 0;
    while ((exp_q0.size() != 0 || exp_q1.size() != 0) && waited < drain_limit) begin
      @(posedge clk);
      waited++;
    end
    if (exp_q0.size() != 0 || exp_q1.size() != 0) begin
      $display("ERROR: %0d instructions did not retire within %0d cycles",
               exp_q0.size() + exp_q1.size(), waited);
      other_errors++;
      exp_q0.delete();
      exp_q1.delete();
    end
    @(negedge clk);
  endtask

  task automatic build_rows();
    // seed registers, same numbers with different values per lane
    add_row(1, encode_i(isa_pkg::op_addi, 5'd0, 5'd1, 16'h0005),
            1, encode_i(isa_pkg::op_addi, 5'd0, 5'd1, 16'h0077), 1);
    add_row(1, encode_i(isa_pkg::op_ori, 5'd0, 5'd2, 16'hf0f0),
            1, encode_i(isa_pkg::op_ori, 5'd0, 5'd2, 16'h1234), 1);
    add_row(1, encode_i(isa_pkg::op_andi, 5'd2, 5'd3, 16'h00ff),
            1, encode_i(isa_pkg::op_andi, 5'd2, 5'd3, 16'h0f0f), 1);
    add_row(1, encode_r(isa_pkg::op_add, 5'd1, 5'd2, 5'd4),
            1, encode_r(isa_pkg::op_sub, 5'd2, 5'd1, 5'd4), 1);
    add_row(1, encode_r(isa_pkg::op_sub, 5'd1, 5'd2, 5'd5),
            1, encode_r(isa_pkg::op_and, 5'd1, 5'd2, 5'd5), 1);
    add_row(1, encode_r(isa_pkg::op_or, 5'd1, 5'd3, 5'd6),
            1, encode_r(isa_pkg::op_slt, 5'd1, 5'd2, 5'd6), 1);
    // r5 in lane 0 is negative here
    add_row(1, encode_r(isa_pkg::op_slt, 5'd5, 5'd1, 5'd7),
            1, encode_r(isa_pkg::op_slt, 5'd2, 5'd1, 5'd7), 1);
    add_row(1, encode_i(isa_pkg::op_addi, 5'd0, 5'd0, 16'h0099),
            1, encode_r(isa_pkg::op_nop, 5'd0, 5'd0, 5'd0), 1);
    add_row(1, encode_r(isa_pkg::op_or, 5'd0, 5'd0, 5'd8), 1, 32'hffff_ffff, 1);
    add_row(1, encode_r(isa_pkg::op_add, 5'd1, 5'd0, 5'd9),
            1, encode_r(isa_pkg::op_add, 5'd1, 5'd0, 5'd9), 1);
    // both lanes hit the memory in the same cycle
    add_row(1, encode_i(isa_pkg::op_sw, 5'd0, 5'd4, 16'h0010),
            1, encode_i(isa_pkg::op_sw, 5'd0, 5'd4, 16'h0011), 1);
    add_row(1, encode_i(isa_pkg::op_lw, 5'd0, 5'd10, 16'h0010),
            1, encode_i(isa_pkg::op_lw, 5'd0, 5'd10, 16'h0011), 1);
    add_row(1, encode_i(isa_pkg::op_sw, 5'd0, 5'd6, 16'h0020), 0, 32'h0, 1);
    add_row(0, 32'h0, 1, encode_i(isa_pkg::op_lw, 5'd0, 5'd11, 16'h0020), 1);
    // rows presented while the lanes are still busy
    add_row(1, encode_i(isa_pkg::op_addi, 5'd1, 5'd12, 16'h0001),
            1, encode_i(isa_pkg::op_addi, 5'd1, 5'd12, 16'h0002), 0);
    add_row(1, encode_r(isa_pkg::op_add, 5'd12, 5'd12, 5'd13),
            1, encode_i(isa_pkg::op_sw, 5'd0, 5'd12, 16'h0030), 0);
    add_row(1, encode_i(isa_pkg::op_addi, 5'd13, 5'd14, 16'h0003),
            1, encode_i(isa_pkg::op_lw, 5'd0, 5'd13, 16'h0030), 1);
  endtask

  initial begin
    reset              = 1'b1;
    instruction0_valid = 1'b0;
    instruction0       = '0;
    instruction1_valid = 1'b0;
    instruction1       = '0;
    checks             = 0;
    mismatches         = 0;
    other_errors       = 0;
    busy_seen          = 0;
    for (int l = 0; l < mem_pkg::num_lanes; l++) begin
      for (int r = 0; r < isa_pkg::num_regs; r++) begin
        model_regs[l][r] = '0;
      end
    end
    build_rows();
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    foreach (rows[i]) begin
      apply_row(rows[i]);
      if (rows[i].drain) begin
        drain_retires();
      end
    end
    drain_retires();

    if (busy_seen == 0) begin
      $display("ERROR: instruction_ready was never seen low while a row was presented");
      other_errors++;
    end

    $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- src.f
source/isa_pkg.sv
source/mem_pkg.sv
source/mem_if.sv
source/control_unit.sv
source/alu.sv
source/exec_lane.sv
source/data_memory.sv
source/processor.sv
tests/tb_clock.sv
tests/tb_processor.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_processor
FILELIST  ?= src.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR)
